/* datachip_pkg.sv */
// data chip slice shared definitions
// widths, opcode names, microinstruction views and ALU function lines
package datachip_pkg;

   localparam int data_w    = 8;    // data path byte
   localparam int mi_w      = 16;   // microinstruction word
   localparam int bus_w     = 16;   // address/data bus
   localparam int reg_count = 26;   // file registers
   localparam int g_w       = 3;    // bank register
   localparam int flag_w    = 4;
   localparam int sel_w     = 4;    // register address code

   // status flag positions in psw
   localparam int flag_c_i = 0;
   localparam int flag_v_i = 1;
   localparam int flag_z_i = 2;
   localparam int flag_n_i = 3;

   // carry-in choice
   localparam logic [1:0] cin_zero = 2'd0;
   localparam logic [1:0] cin_one  = 2'd1;
   localparam logic [1:0] cin_c    = 2'd2;
   localparam logic [1:0] cin_nc   = 2'd3;

   // write-back byte source
   localparam logic [1:0] md_alu = 2'd0;
   localparam logic [1:0] md_lo  = 2'd1;
   localparam logic [1:0] md_hi  = 2'd2;

   typedef enum logic [2:0] {
      op_add, op_sub, op_and, op_or, op_xor, op_mov, op_ldb, op_out
   } alu_op_e;

   typedef struct packed {
      logic       form;       // 1 here
      alu_op_e    op;
      logic       byte_hi;
      logic       adc;
      logic       g_we;
      logic       flags_en;
      logic [3:0] b_sel;
      logic [3:0] a_sel;
   } mi_reg_t;

   typedef struct packed {
      logic       form;       // 0 here
      alu_op_e    op;
      logic [7:0] imm;        // port B value
      logic [3:0] a_sel;
   } mi_imm_t;

   typedef union packed {
      mi_reg_t rf;
      mi_imm_t im;
   } mi_word_t;

   // or_fn indexed by {a,b}, and_fn is generate for ab = 11, 10, 01
   typedef struct packed {
      logic [3:0] or_fn;
      logic [2:0] and_fn;
   } alu_fn_t;

   localparam alu_fn_t fn_add = '{or_fn: 4'b0110, and_fn: 3'b001};
   localparam alu_fn_t fn_sub = '{or_fn: 4'b1001, and_fn: 3'b010};   // a + ~b
   localparam alu_fn_t fn_and = '{or_fn: 4'b1000, and_fn: 3'b000};
   localparam alu_fn_t fn_or  = '{or_fn: 4'b1110, and_fn: 3'b000};
   localparam alu_fn_t fn_xor = '{or_fn: 4'b0110, and_fn: 3'b000};
   localparam alu_fn_t fn_mov = '{or_fn: 4'b1010, and_fn: 3'b000};   // pass b

endpackage

/* micro_ctl_if.sv */
// decoded microinstruction control
// from the decoder to the register file, ALU and bus port
`timescale 1ns/1ps
interface micro_ctl_if;
   import datachip_pkg::*;

   logic               exec;       // valid and not waiting
   logic               stall;      // bus wait, hold all state
   logic [sel_w-1:0]   a_sel;
   logic [sel_w-1:0]   b_sel;
   logic               imm_sel;
   logic [data_w-1:0]  imm;
   logic               rf_we;
   logic               g_we;
   alu_fn_t            fn;
   logic [1:0]         cin_mode;
   logic               borrow;
   logic               arith;      // C and V
   logic               flags_we;   // Z and N
   logic [1:0]         md_sel;
   logic               ad_stb;

   modport decoder (
      output exec, stall, a_sel, b_sel, imm_sel, imm, rf_we, g_we, fn,
             cin_mode, borrow, arith, flags_we, md_sel, ad_stb
   );

   modport datapath (
      input exec, stall, a_sel, b_sel, imm_sel, imm, rf_we, g_we, fn,
            cin_mode, borrow, arith, flags_we, md_sel, ad_stb
   );
endinterface

/* mir_decode.sv */
// microinstruction register and decoder
// holds the word and its valid bit, decodes function lines and enables
`timescale 1ns/1ps
module mir_decode
(
   input  logic                   pin_clk,
   input  logic                   reset,
   input  logic                   bus_wait,
   input  logic                   mi_load,
   input  datachip_pkg::mi_word_t mi,
   input  logic                   flag_c,
   micro_ctl_if.decoder           ctl
);
   import datachip_pkg::*;

   mi_word_t   mi_q;
   logic       valid;
   alu_op_e    op;
   logic       is_reg;
   logic       adc;
   logic       flags_on;
   logic [1:0] raw_cin;
   logic       rf_we_d;
   logic       ad_stb_d;

   // wait freezes both word and valid bit
   always_ff @(posedge pin_clk)
   begin
      if (reset)
      begin
         mi_q  <= '0;
         valid <= 1'b0;
      end
      else if (!bus_wait)
      begin
         valid <= mi_load;
         if (mi_load)
            mi_q <= mi;
      end
   end

   assign is_reg   = mi_q.rf.form;
   assign op       = mi_q.rf.op;               // same bits in both views
   assign adc      = is_reg & mi_q.rf.adc;
   assign flags_on = ~is_reg | mi_q.rf.flags_en; // immediate form always sets flags

   always_comb
   begin
      ctl.fn       = fn_mov;
      raw_cin      = cin_zero;
      ctl.borrow   = 1'b0;
      ctl.arith    = 1'b0;
      ctl.flags_we = flags_on;
      ctl.md_sel   = md_alu;
      rf_we_d      = 1'b1;
      ad_stb_d     = 1'b0;
      case (op)
         op_add:
         begin
            ctl.fn    = fn_add;
            raw_cin   = adc ? cin_c : cin_zero;
            ctl.arith = flags_on;
         end
         op_sub:
         begin
            ctl.fn     = fn_sub;
            raw_cin    = adc ? cin_nc : cin_one;   // C holds the borrow
            ctl.borrow = 1'b1;
            ctl.arith  = flags_on;
         end
         op_and: ctl.fn = fn_and;
         op_or:  ctl.fn = fn_or;
         op_xor: ctl.fn = fn_xor;
         op_ldb: ctl.md_sel = (is_reg & mi_q.rf.byte_hi) ? md_hi : md_lo;
         op_out:
         begin
            rf_we_d      = 1'b0;
            ad_stb_d     = 1'b1;
            ctl.flags_we = 1'b0;
         end
         default: ctl.fn = fn_mov;
      endcase
   end

   // fold the current C into a fixed carry-in
   always_comb
   begin
      case (raw_cin)
         cin_c:   ctl.cin_mode = flag_c ? cin_one : cin_zero;
         cin_nc:  ctl.cin_mode = flag_c ? cin_zero : cin_one;
         default: ctl.cin_mode = raw_cin;
      endcase
   end

   assign ctl.exec    = valid & ~bus_wait;
   assign ctl.stall   = bus_wait;
   assign ctl.a_sel   = mi_q.rf.a_sel;
   assign ctl.b_sel   = mi_q.rf.b_sel;
   assign ctl.imm_sel = ~is_reg;
   assign ctl.imm     = mi_q.im.imm;
   assign ctl.rf_we   = rf_we_d;
   assign ctl.g_we    = is_reg & mi_q.rf.g_we;
   assign ctl.ad_stb  = ad_stb_d;

   // no register write-back on an output strobe
   a_no_we_with_out : assert property (@(posedge pin_clk) disable iff (reset)
      ctl.exec |-> !(ctl.rf_we && ctl.ad_stb));

endmodule

/* bank_regfile.sv */
// banked register file, 26 x 8 with two read ports
// G selects the bank for codes 0 and 1, other codes are fixed or aliases
`timescale 1ns/1ps
module bank_regfile
(
   input  logic                              pin_clk,
   input  logic                              reset,
   micro_ctl_if.datapath                     ctl,
   input  logic [datachip_pkg::data_w-1:0]   md,
   output logic [datachip_pkg::data_w-1:0]   fa,
   output logic [datachip_pkg::data_w-1:0]   fb
);
   import datachip_pkg::*;

   logic [data_w-1:0]    regs [reg_count];
   logic [g_w-1:0]       g;
   logic [reg_count-1:0] sel_a;
   logic [reg_count-1:0] sel_b;
   logic [data_w-1:0]    rb;

   function automatic logic [reg_count-1:0] sel_decode(input logic [sel_w-1:0] code,
                                                       input logic [g_w-1:0] g_cur);
      logic [reg_count-1:0] sel;
      int                   idx;
      sel = '0;
      if (code[sel_w-1:1] == '0)
      begin
         if (g_cur < 3'd6)
            idx = 2 * int'(g_cur) + int'(code[0]);
         else if (g_cur == 3'd7)
            idx = code[0] ? 12 : 13;
         else
            idx = code[0] ? 14 : 15;
      end
      else
         idx = reg_count + 1 - int'(code);   // 15..12 -> 12..15, 11..2 -> 16..25
      sel[idx] = 1'b1;
      return sel;
   endfunction

   assign sel_a = sel_decode(ctl.a_sel, g);
   assign sel_b = sel_decode(ctl.b_sel, g);

   // and-or read mux
   always_comb
   begin
      fa = '0;
      rb = '0;
      for (int k = 0; k < reg_count; k++)
      begin
         fa = fa | (regs[k] & {data_w{sel_a[k]}});
         rb = rb | (regs[k] & {data_w{sel_b[k]}});
      end
   end

   assign fb = ctl.imm_sel ? ctl.imm : rb;

   always_ff @(posedge pin_clk)
   begin
      if (reset)
      begin
         g <= '0;
         for (int k = 0; k < reg_count; k++)
            regs[k] <= '0;
      end
      else if (ctl.exec)
      begin
         if (ctl.g_we)
            g <= fa[g_w-1:0];   // fa was read with the old bank
         if (ctl.rf_we)
         begin
            for (int k = 0; k < reg_count; k++)
               if (sel_a[k])
                  regs[k] <= md;
         end
      end
   end

   a_sel_onehot : assert property (@(posedge pin_clk) disable iff (reset)
      $onehot(sel_a) && $onehot(sel_b));

endmodule

/* alu_slice.sv */
// 8-bit ALU programmed by propagate/generate function lines
// ripple carry chain and the C, V, Z, N status register
`timescale 1ns/1ps
module alu_slice
(
   input  logic                              pin_clk,
   input  logic                              reset,
   micro_ctl_if.datapath                     ctl,
   input  logic [datachip_pkg::data_w-1:0]   fa,
   input  logic [datachip_pkg::data_w-1:0]   fb,
   input  logic [datachip_pkg::data_w-1:0]   md,
   output logic [datachip_pkg::data_w-1:0]   alu_res,
   output logic                              flag_c,
   output logic [datachip_pkg::flag_w-1:0]   psw
);
   import datachip_pkg::*;

   logic [data_w-1:0] ax;   // propagate, also the half sum
   logic [data_w-1:0] ay;   // generate
   logic [data_w:0]   c;    // c[0] is carry in
   logic              alu_c;
   logic              alu_v;

   function automatic logic and_term(input alu_fn_t f, input logic a, input logic b);
      logic t;
      case ({a, b})
         2'b11:   t = f.and_fn[0];
         2'b10:   t = f.and_fn[1];
         2'b01:   t = f.and_fn[2];
         default: t = 1'b0;
      endcase
      return t;
   endfunction

   // the decoder has already folded C into a fixed carry in
   always_comb
   begin
      case (ctl.cin_mode)
         cin_one: c[0] = 1'b1;
         default: c[0] = 1'b0;
      endcase
      for (int i = 0; i < data_w; i++)
      begin
         ax[i]      = ctl.fn.or_fn[{fa[i], fb[i]}];
         ay[i]      = and_term(ctl.fn, fa[i], fb[i]);
         c[i+1]     = ay[i] | (ax[i] & c[i]);
         alu_res[i] = ax[i] ^ c[i];
      end
   end

   assign alu_c = c[data_w] ^ ctl.borrow;
   assign alu_v = c[data_w-1] ^ c[data_w];   // into bit 7 vs out of bit 7

   always_ff @(posedge pin_clk)
   begin
      if (reset)
         psw <= '0;
      else if (ctl.exec)
      begin
         if (ctl.arith)
         begin
            psw[flag_c_i] <= alu_c;
            psw[flag_v_i] <= alu_v;
         end
         if (ctl.flags_we)
         begin
            psw[flag_z_i] <= (md == '0);   // from the write-back byte
            psw[flag_n_i] <= md[data_w-1];
         end
      end
   end

   assign flag_c = psw[flag_c_i];

endmodule

/* bus_port.sv */
// bus side of the slice
// input latch, write-back byte select and the {B, A} output latch
`timescale 1ns/1ps
module bus_port
(
   input  logic                              pin_clk,
   input  logic                              reset,
   micro_ctl_if.datapath                     ctl,
   input  logic [datachip_pkg::bus_w-1:0]    ad_in,
   input  logic                              ad_in_stb,
   input  logic [datachip_pkg::data_w-1:0]   fa,
   input  logic [datachip_pkg::data_w-1:0]   fb,
   input  logic [datachip_pkg::data_w-1:0]   alu_res,
   output logic [datachip_pkg::data_w-1:0]   md,
   output logic [datachip_pkg::bus_w-1:0]    ad_out,
   output logic                              ad_oe
);
   import datachip_pkg::*;

   logic [bus_w-1:0] dal;   // latched bus input

   // capture runs regardless of wait
   always_ff @(posedge pin_clk)
   begin
      if (ad_in_stb)
         dal <= ad_in;
   end

   always_comb
   begin
      case (ctl.md_sel)
         md_lo:   md = dal[data_w-1:0];
         md_hi:   md = dal[bus_w-1:data_w];
         default: md = alu_res;
      endcase
   end

   always_ff @(posedge pin_clk)
   begin
      if (reset)
         ad_oe <= 1'b0;
      else if (!ctl.stall)
         ad_oe <= ctl.exec & ctl.ad_stb;   // drops on the next quiet edge
   end

   always_ff @(posedge pin_clk)
   begin
      if (!ctl.stall && ctl.exec && ctl.ad_stb)
         ad_out <= {fb, fa};
   end

   a_oe_after_reset : assert property (@(posedge pin_clk) reset |=> !ad_oe);

endmodule

/* datachip_top.sv */
// 8-bit microcoded data path slice
// decoder, banked register file, ALU and bus port
`timescale 1ns/1ps
module datachip_top
(
   input  logic                              pin_clk,
   input  logic                              reset,
   input  logic                              bus_wait,
   input  logic                              mi_load,
   input  logic [datachip_pkg::mi_w-1:0]     mi,
   input  logic [datachip_pkg::bus_w-1:0]    ad_in,
   input  logic                              ad_in_stb,
   output logic [datachip_pkg::bus_w-1:0]    ad_out,
   output logic                              ad_oe,
   output logic [datachip_pkg::flag_w-1:0]   psw
);
   import datachip_pkg::*;

   logic [data_w-1:0] fa;        // port A, also write target
   logic [data_w-1:0] fb;
   logic [data_w-1:0] alu_res;
   logic [data_w-1:0] md;        // write-back byte
   logic              flag_c;

   micro_ctl_if ctl ();

   mir_decode i_mir_decode (
      .pin_clk  (pin_clk),
      .reset    (reset),
      .bus_wait (bus_wait),
      .mi_load  (mi_load),
      .mi       (mi),
      .flag_c   (flag_c),
      .ctl      (ctl.decoder)
   );

   bank_regfile i_bank_regfile (
      .pin_clk (pin_clk),
      .reset   (reset),
      .ctl     (ctl.datapath),
      .md      (md),
      .fa      (fa),
      .fb      (fb)
   );

   alu_slice i_alu_slice (
      .pin_clk (pin_clk),
      .reset   (reset),
      .ctl     (ctl.datapath),
      .fa      (fa),
      .fb      (fb),
      .md      (md),
      .alu_res (alu_res),
      .flag_c  (flag_c),
      .psw     (psw)
   );

   bus_port i_bus_port (
      .pin_clk   (pin_clk),
      .reset     (reset),
      .ctl       (ctl.datapath),
      .ad_in     (ad_in),
      .ad_in_stb (ad_in_stb),
      .fa        (fa),
      .fb        (fb),
      .alu_res   (alu_res),
      .md        (md),
      .ad_out    (ad_out),
      .ad_oe     (ad_oe)
   );

endmodule

/* tb_datachip.sv */
// testbench for the 8-bit data path slice
// directed tests checked against a behavioural model of registers, G and flags
`timescale 1ns/1ps
module tb_datachip;
   import datachip_pkg::*;

   localparam int period = 40;

   logic        pin_clk;
   logic        reset;
   logic        bus_wait;
   logic        mi_load;
   logic [15:0] mi;
   logic [15:0] ad_in;
   logic        ad_in_stb;
   logic [15:0] ad_out;
   logic        ad_oe;
   logic [3:0]  psw;

   logic [7:0]  m_regs [26];   // expected file contents
   logic [2:0]  m_g;
   logic [3:0]  m_psw;         // N Z V C
   logic [15:0] m_dal;
   int          errors;
   int          checks;
   int          tests;
   int          issued;        // stimulus cycles, sets the watchdog limit
   int          test_err;
   string       cur_test;
   int unsigned rnd_seed;

   datachip_top i_dut (
      .pin_clk   (pin_clk),
      .reset     (reset),
      .bus_wait  (bus_wait),
      .mi_load   (mi_load),
      .mi        (mi),
      .ad_in     (ad_in),
      .ad_in_stb (ad_in_stb),
      .ad_out    (ad_out),
      .ad_oe     (ad_oe),
      .psw       (psw)
   );

   always #(period / 2) pin_clk = ~pin_clk;

   // address map: codes 0/1 banked by G, 12..15 alias, 2..11 fixed
   function automatic int reg_index(input logic [3:0] code, input logic [2:0] g);
      int idx;
      if (code >= 4'd12)
         idx = 12 + (15 - int'(code));
      else if (code >= 4'd2)
         idx = 16 + (11 - int'(code));
      else if (g == 3'd7)
         idx = (code == 4'd1) ? 12 : 13;
      else if (g == 3'd6)
         idx = (code == 4'd1) ? 14 : 15;
      else
         idx = 2 * int'(g) + int'(code);
      return idx;
   endfunction

   function automatic logic [15:0] reg_word(input logic [2:0] op, input logic hi,
                                            input logic adc, input logic gwe, input logic fen,
                                            input logic [3:0] b, input logic [3:0] a);
      return {1'b1, op, hi, adc, gwe, fen, b, a};
   endfunction

   function automatic logic [15:0] imm_word(input logic [2:0] op, input logic [7:0] imm,
                                            input logic [3:0] a);
      return {1'b0, op, imm, a};
   endfunction

   task automatic model_exec(input logic [15:0] w);
      logic [7:0] a;
      logic [7:0] b;
      logic [7:0] res;
      logic [8:0] sum;
      logic [7:0] low;        // bit 7 is the carry into the sign bit
      logic       cin;
      logic       form;
      logic       flags_on;
      logic       arith;
      int         ai;
      form     = w[15];
      flags_on = !form || w[8];
      arith    = (w[14:12] == op_add) || (w[14:12] == op_sub);
      ai       = reg_index(w[3:0], m_g);
      a        = m_regs[ai];
      b        = form ? m_regs[reg_index(w[7:4], m_g)] : w[11:4];
      if (w[14:12] == op_sub)
      begin
         b   = ~b;
         cin = (form && w[10]) ? !m_psw[0] : 1'b1;
      end
      else
         cin = (form && w[10]) ? m_psw[0] : 1'b0;
      sum = {1'b0, a} + {1'b0, b} + cin;
      low = {1'b0, a[6:0]} + {1'b0, b[6:0]} + cin;
      case (w[14:12])
         op_and:  res = a & b;
         op_or:   res = a | b;
         op_xor:  res = a ^ b;
         op_mov:  res = b;
         op_ldb:  res = (form && w[11]) ? m_dal[15:8] : m_dal[7:0];
         default: res = sum[7:0];
      endcase
      if (w[14:12] != op_out)
      begin
         m_regs[ai] = res;
         if (flags_on)
         begin
            m_psw[2] = (res == 8'h00);
            m_psw[3] = res[7];
         end
         if (flags_on && arith)
         begin
            m_psw[0] = sum[8] ^ (w[14:12] == op_sub);   // borrow on subtract
            m_psw[1] = low[7] ^ sum[8];
         end
      end
      if (form && w[9])
         m_g = a[2:0];   // old A value, old bank
   endtask

   task automatic check(input string what, input logic [15:0] exp, input logic [15:0] act);
      checks++;
      if (act !== exp)
      begin
         $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
         errors++;
      end
   endtask

   task automatic step(input logic [15:0] word, input logic load);
      @(posedge pin_clk);
      #2;
      mi        = word;
      mi_load   = load;
      ad_in_stb = 1'b0;
      issued++;
   endtask

   task automatic issue(input logic [15:0] word);
      step(word, 1'b1);
      model_exec(word);
   endtask

   task automatic strobe_bus(input logic [15:0] word);
      step(16'h0000, 1'b0);
      ad_in     = word;
      ad_in_stb = 1'b1;
      m_dal     = word;
   endtask

   task automatic set_bank(input logic [2:0] k);
      issue(imm_word(op_mov, {5'b0, k}, 4'd11));
      issue(reg_word(op_mov, 1'b0, 1'b0, 1'b1, 1'b0, 4'd11, 4'd11));   // G from reg 16
   endtask

   // op_out puts {B, A} on the bus one edge after it executes
   task automatic read_pair(input logic [3:0] a_code, input logic [3:0] b_code);
      logic [15:0] exp;
      logic        seen;
      exp  = {m_regs[reg_index(b_code, m_g)], m_regs[reg_index(a_code, m_g)]};
      seen = 1'b0;
      step(reg_word(op_out, 1'b0, 1'b0, 1'b0, 1'b0, b_code, a_code), 1'b1);
      step(16'h0000, 1'b0);
      for (int n = 0; n < 4 && !seen; n++)
      begin
         @(posedge pin_clk);
         #1;
         seen = ad_oe;
      end
      if (!seen)
      begin
         $display("%s: output enable never rose when reading codes %0d and %0d",
                  cur_test, a_code, b_code);
         errors++;
      end
      else
         check($sformatf("codes %0d/%0d", a_code, b_code), exp, ad_out);
      check("psw", m_psw, psw);
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      test_err = errors;
   endtask

   task automatic end_test();
      tests++;
      $display("test %s: %s, %0d errors", cur_test,
               (errors == test_err) ? "passed" : "failed", errors - test_err);
   endtask

   task automatic reset_state();
      start_test("reset_state");
      check("ad_oe", 16'h0000, {15'b0, ad_oe});
      check("psw", 16'h0000, psw);
      for (int c = 0; c < 16; c += 2)
         read_pair(4'(c), 4'(c + 1));
      end_test();
   endtask

   task automatic imm_arith();
      start_test("imm_arith");
      issue(imm_word(op_mov, 8'h7f, 4'd2));
      issue(imm_word(op_add, 8'h01, 4'd2));   // signed overflow into 0x80
      read_pair(4'd2, 4'd2);
      issue(imm_word(op_mov, 8'hff, 4'd3));
      issue(imm_word(op_add, 8'h01, 4'd3));
      read_pair(4'd3, 4'd2);
      check("carry out of 0xff + 1", 16'h0005, psw);
      issue(imm_word(op_add, 8'($urandom), 4'd2));
      read_pair(4'd2, 4'd3);
      end_test();
   endtask

   task automatic reg_arith();
      logic [2:0] op;
      logic [3:0] a;
      logic [3:0] b;
      start_test("reg_arith");
      for (int k = 4; k < 10; k++)
         issue(imm_word(op_mov, 8'($urandom), 4'(k)));
      for (int n = 0; n < 12; n++)
      begin
         op = 3'(1 + $urandom % 4);   // sub, and, or, xor
         a  = 4'(4 + $urandom % 6);
         b  = 4'(4 + $urandom % 6);
         issue(reg_word(op, 1'b0, 1'b0, 1'b0, 1'($urandom % 2), b, a));
         read_pair(a, b);
      end
      issue(reg_word(op_sub, 1'b0, 1'b0, 1'b0, 1'b1, 4'd5, 4'd4));
      issue(reg_word(op_add, 1'b0, 1'b1, 1'b0, 1'b1, 4'd7, 4'd6));   // carry in from sub
      read_pair(4'd6, 4'd7);
      issue(reg_word(op_sub, 1'b0, 1'b1, 1'b0, 1'b1, 4'd9, 4'd8));
      read_pair(4'd8, 4'd9);
      end_test();
   endtask

   task automatic bank_alias();
      start_test("bank_alias");
      for (int k = 0; k < 8; k++)
      begin
         set_bank(3'(k));
         issue(imm_word(op_mov, 8'($urandom), 4'd0));
         issue(imm_word(op_mov, 8'($urandom), 4'd1));
         read_pair(4'd0, 4'd1);
      end
      for (int k = 6; k < 8; k++)
      begin
         set_bank(3'(k));
         read_pair(4'd12, 4'd13);
         read_pair(4'd14, 4'd15);
      end
      for (int k = 0; k < 6; k++)
      begin
         set_bank(3'(k));
         read_pair(4'd1, 4'd0);
      end
      for (int c = 2; c < 12; c++)
         issue(imm_word(op_mov, 8'($urandom), 4'(c)));
      for (int c = 2; c < 12; c += 2)
         read_pair(4'(c), 4'(c + 1));
      end_test();
   endtask

   task automatic bus_byte_load();
      start_test("bus_byte_load");
      for (int n = 0; n < 6; n++)
      begin
         strobe_bus((n < 4) ? 16'($urandom) : 16'h0080);   // last two hit N then Z
         issue(reg_word(op_ldb, 1'(n % 2), 1'b0, 1'b0, 1'b1, 4'd0, 4'd5));
         read_pair(4'd5, 4'd5);
      end
      end_test();
   endtask

   task automatic wait_stall();
      logic [15:0] shown;
      logic [15:0] first;
      logic [15:0] ignored;
      logic [15:0] second;
      start_test("wait_stall");
      shown   = {m_regs[reg_index(4'd8, m_g)], m_regs[reg_index(4'd6, m_g)]};
      first   = imm_word(op_add, 8'h9c, 4'd6);
      ignored = imm_word(op_mov, 8'haa, 4'd7);
      second  = imm_word(op_sub, 8'h21, 4'd8);
      // output strobe just ahead, so ad_oe is high when wait starts
      step(reg_word(op_out, 1'b0, 1'b0, 1'b0, 1'b0, 4'd8, 4'd6), 1'b1);
      step(first, 1'b1);
      step(ignored, 1'b1);
      bus_wait = 1'b1;
      for (int n = 0; n < 4; n++)
      begin
         step(ignored, 1'b1);
         check("psw held", m_psw, psw);
         check("ad_oe held", 16'h0001, {15'b0, ad_oe});
         check("ad_out held", shown, ad_out);
      end
      step(second, 1'b1);
      bus_wait = 1'b0;
      model_exec(first);   // pending one completes, then the new one
      model_exec(second);
      read_pair(4'd6, 4'd8);
      read_pair(4'd7, 4'd7);
      end_test();
   endtask

   initial
   begin
      rnd_seed  = $urandom(73);
      pin_clk   = 1'b0;
      reset     = 1'b1;
      bus_wait  = 1'b0;
      mi_load   = 1'b0;
      mi        = 16'h0000;
      ad_in     = 16'h0000;
      ad_in_stb = 1'b0;
      errors    = 0;
      checks    = 0;
      tests     = 0;
      issued    = 0;
      m_g       = 3'd0;
      m_psw     = 4'h0;
      m_dal     = 16'h0000;
      for (int k = 0; k < 26; k++)
         m_regs[k] = 8'h00;
      repeat (3) @(posedge pin_clk);
      #2;
      reset = 1'b0;
      reset_state();
      imm_arith();
      reg_arith();
      bank_alias();
      bus_byte_load();
      wait_stall();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   // limit grows with the stimulus issued so far
   initial
   begin
      while ($time < longint'(issued + 8) * period * 4)
         @(posedge pin_clk);
      $display("timeout: run stopped after %0d issued cycles without finishing", issued);
      $display("Errors found");
      $finish;
   end

endmodule

/* datachip.f */
datachip_pkg.sv
micro_ctl_if.sv
mir_decode.sv
bank_regfile.sv
alu_slice.sv
bus_port.sv
datachip_top.sv
tb_datachip.sv

/* Bender.yml */
package:
  name: datachip

sources:
  - datachip_pkg.sv
  - micro_ctl_if.sv
  - mir_decode.sv
  - bank_regfile.sv
  - alu_slice.sv
  - bus_port.sv
  - datachip_top.sv
  - target: simulation
    files:
      - tb_datachip.sv
